// File: include/rv_core_config.svh
`ifndef RV_CORE_CONFIG_SVH
`define RV_CORE_CONFIG_SVH

// datapath sizes
`define RV_XLEN        32
`define RV_REG_ADDR_W  5
`define RV_REG_COUNT   32

// RV32I major opcodes, bits [6:0] of the instruction
`define RV_OP_REG      7'b0110011
`define RV_OP_IMM      7'b0010011
`define RV_OP_LUI      7'b0110111
`define RV_OP_AUIPC    7'b0010111
`define RV_OP_JAL      7'b1101111
`define RV_OP_JALR     7'b1100111
`define RV_OP_BRANCH   7'b1100011

`endif

// File: source/rv_core_pkg.sv
`include "rv_core_config.svh"

package rv_core_pkg;

  // one instruction word, seen through the RV32I encoding formats
  typedef union packed {
    struct packed {
      logic [6:0]                funct7;
      logic [`RV_REG_ADDR_W-1:0] rs2;
      logic [`RV_REG_ADDR_W-1:0] rs1;
      logic [2:0]                funct3;
      logic [`RV_REG_ADDR_W-1:0] rd;
      logic [6:0]                opcode;
    } r;
    struct packed {
      logic [11:0]               imm;
      logic [`RV_REG_ADDR_W-1:0] rs1;
      logic [2:0]                funct3;
      logic [`RV_REG_ADDR_W-1:0] rd;
      logic [6:0]                opcode;
    } i;
    struct packed {
      logic                      imm_12;
      logic [5:0]                imm_10_5;
      logic [`RV_REG_ADDR_W-1:0] rs2;
      logic [`RV_REG_ADDR_W-1:0] rs1;
      logic [2:0]                funct3;
      logic [3:0]                imm_4_1;
      logic                      imm_11;
      logic [6:0]                opcode;
    } b;
    // U and J share the layout, J scrambles the upper field
    struct packed {
      logic [19:0]               upper;
      logic [`RV_REG_ADDR_W-1:0] rd;
      logic [6:0]                opcode;
    } uj;
  } instr_t;

endpackage

// File: source/rv_regfile.sv
`timescale 1ns/1ps
`include "rv_core_config.svh"

module rv_regfile (
  input  logic                      clock,
  input  logic                      reset,
  input  logic [`RV_REG_ADDR_W-1:0] rs1_addr_i,
  input  logic [`RV_REG_ADDR_W-1:0] rs2_addr_i,
  output logic [`RV_XLEN-1:0]       rs1_data_o,
  output logic [`RV_XLEN-1:0]       rs2_data_o,
  input  logic                      we_i,
  input  logic [`RV_REG_ADDR_W-1:0] waddr_i,
  input  logic [`RV_XLEN-1:0]       wdata_i
);

  logic [`RV_XLEN-1:0] regs [`RV_REG_COUNT];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int n = 0; n < `RV_REG_COUNT; n++) begin
        regs[n] <= '0;
      end
    end else if (we_i) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  // x0 reads as zero whatever was stored there
  assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
  assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

endmodule

// File: source/rv_decoder.sv
`timescale 1ns/1ps
`include "rv_core_config.svh"

module rv_decoder import rv_core_pkg::*; (
  input  logic                      clock,
  input  logic                      reset,

  // strobe from the fetcher
  input  logic                      instr_valid_i,
  input  instr_t                    instr_i,
  input  logic [`RV_XLEN-1:0]       pc_i,

  // register file read side
  output logic [`RV_REG_ADDR_W-1:0] rs1_addr_o,
  output logic [`RV_REG_ADDR_W-1:0] rs2_addr_o,
  input  logic [`RV_XLEN-1:0]       rs1_data_i,
  input  logic [`RV_XLEN-1:0]       rs2_data_i,

  // result of the instruction in the execute register
  input  logic                      fwd_we_i,
  input  logic [`RV_REG_ADDR_W-1:0] fwd_rd_i,
  input  logic [`RV_XLEN-1:0]       fwd_data_i,

  // to execute
  output logic                      valid_o,
  output instr_t                    instr_o,
  output logic [`RV_XLEN-1:0]       pc_o,
  output logic [`RV_XLEN-1:0]       op_a_o,
  output logic [`RV_XLEN-1:0]       op_b_o
);

  logic                valid_q;
  instr_t              instr_q;
  logic [`RV_XLEN-1:0] pc_q;
  logic                fwd_rs1;
  logic                fwd_rs2;

  always_ff @(posedge clock) begin
    if (reset) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= instr_valid_i;
    end
  end

  always_ff @(posedge clock) begin
    if (instr_valid_i) begin
      instr_q <= instr_i;
      pc_q    <= pc_i;
    end
  end

  // operands are read in the decode cycle from the held word
  assign rs1_addr_o = instr_q.r.rs1;
  assign rs2_addr_o = instr_q.r.rs2;

  // the older instruction n-2 is already in the register file,
  // only n-1 in the execute register needs a bypass
  assign fwd_rs1 = fwd_we_i && (fwd_rd_i == rs1_addr_o);
  assign fwd_rs2 = fwd_we_i && (fwd_rd_i == rs2_addr_o);

  assign op_a_o = fwd_rs1 ? fwd_data_i : rs1_data_i;
  assign op_b_o = fwd_rs2 ? fwd_data_i : rs2_data_i;

  assign valid_o = valid_q;
  assign instr_o = instr_q;
  assign pc_o    = pc_q;

endmodule

// File: source/rv_execute.sv
`timescale 1ns/1ps
`include "rv_core_config.svh"

module rv_execute import rv_core_pkg::*; (
  input  logic                clock,
  input  logic                reset,

  input  logic                valid_i,
  input  instr_t              instr_i,
  input  logic [`RV_XLEN-1:0] pc_i,
  input  logic [`RV_XLEN-1:0] op_a_i,
  input  logic [`RV_XLEN-1:0] op_b_i,

  output logic                valid_o,
  output instr_t              instr_o,
  output logic [`RV_XLEN-1:0] pc_o,
  output logic [`RV_XLEN-1:0] alu_result_o,
  output logic                branch_taken_o
);

  localparam int SHAMT_W = $clog2(`RV_XLEN);

  logic [`RV_XLEN-1:0] imm_i;
  logic [`RV_XLEN-1:0] alu_b;
  logic [`RV_XLEN-1:0] alu_res;
  logic [SHAMT_W-1:0]  shamt;
  logic                use_imm;
  logic                is_sub;
  logic                cond;

  assign imm_i   = {{(`RV_XLEN-12){instr_i.i.imm[11]}}, instr_i.i.imm};
  assign use_imm = (instr_i.i.opcode == `RV_OP_IMM) || (instr_i.i.opcode == `RV_OP_JALR);
  assign alu_b   = use_imm ? imm_i : op_b_i;
  assign shamt   = alu_b[SHAMT_W-1:0];
  // no SUBI, funct7 only selects subtraction for register ops
  assign is_sub  = (instr_i.r.opcode == `RV_OP_REG) && instr_i.r.funct7[5];

  always_comb begin
    alu_res = op_a_i + alu_b;
    if (instr_i.r.opcode != `RV_OP_JALR) begin
      case (instr_i.r.funct3)
        3'b000: alu_res = is_sub ? op_a_i - alu_b : op_a_i + alu_b;
        3'b001: alu_res = op_a_i << shamt;
        3'b010: alu_res = {{(`RV_XLEN-1){1'b0}}, $signed(op_a_i) < $signed(alu_b)};
        3'b011: alu_res = {{(`RV_XLEN-1){1'b0}}, op_a_i < alu_b};
        3'b100: alu_res = op_a_i ^ alu_b;
        3'b101: begin
          // funct7 bit 5 is imm[10] for the immediate shifts
          if (instr_i.r.funct7[5]) begin
            alu_res = $signed(op_a_i) >>> shamt;
          end else begin
            alu_res = op_a_i >> shamt;
          end
        end
        3'b110: alu_res = op_a_i | alu_b;
        default: alu_res = op_a_i & alu_b;
      endcase
    end
  end

  // branches compare rs1 against rs2, never the immediate
  always_comb begin
    case (instr_i.b.funct3)
      3'b000: cond = (op_a_i == op_b_i);
      3'b001: cond = (op_a_i != op_b_i);
      3'b100: cond = $signed(op_a_i) < $signed(op_b_i);
      3'b101: cond = $signed(op_a_i) >= $signed(op_b_i);
      3'b110: cond = op_a_i < op_b_i;
      3'b111: cond = op_a_i >= op_b_i;
      default: cond = 1'b0;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= valid_i;
    end
  end

  always_ff @(posedge clock) begin
    instr_o        <= instr_i;
    pc_o           <= pc_i;
    alu_result_o   <= alu_res;
    branch_taken_o <= (instr_i.b.opcode == `RV_OP_BRANCH) && cond;
  end

endmodule

// File: source/rv_writeback.sv
`timescale 1ns/1ps
`include "rv_core_config.svh"

module rv_writeback import rv_core_pkg::*; (
  input  logic                      clock,
  input  logic                      reset,

  input  logic                      valid_i,
  input  instr_t                    instr_i,
  input  logic [`RV_XLEN-1:0]       pc_i,
  input  logic [`RV_XLEN-1:0]       alu_result_i,
  input  logic                      branch_taken_i,

  // bypass into the decode cycle
  output logic                      fwd_we_o,
  output logic [`RV_REG_ADDR_W-1:0] fwd_rd_o,
  output logic [`RV_XLEN-1:0]       fwd_data_o,

  output logic                      rf_we_o,
  output logic [`RV_REG_ADDR_W-1:0] rf_waddr_o,
  output logic [`RV_XLEN-1:0]       rf_wdata_o,

  output logic                      wb_valid_o,
  output logic                      wb_we_o,
  output logic [`RV_REG_ADDR_W-1:0] wb_rd_o,
  output logic [`RV_XLEN-1:0]       wb_data_o,
  output logic                      redirect_valid_o,
  output logic [`RV_XLEN-1:0]       redirect_pc_o
);

  logic [6:0]          opcode;
  logic [`RV_XLEN-1:0] imm_u;
  logic [`RV_XLEN-1:0] imm_j;
  logic [`RV_XLEN-1:0] imm_b;
  logic [`RV_XLEN-1:0] result;
  logic [`RV_XLEN-1:0] target;
  logic                writes_rd;
  logic                we;
  logic                redirect;

  assign opcode = instr_i.uj.opcode;
  assign imm_u  = {instr_i.uj.upper, 12'b0};
  // J layout in the upper field: imm[20|10:1|11|19:12]
  assign imm_j  = {{(`RV_XLEN-20){instr_i.uj.upper[19]}}, instr_i.uj.upper[7:0],
                   instr_i.uj.upper[8], instr_i.uj.upper[18:9], 1'b0};
  assign imm_b  = {{(`RV_XLEN-12){instr_i.b.imm_12}}, instr_i.b.imm_11,
                   instr_i.b.imm_10_5, instr_i.b.imm_4_1, 1'b0};

  always_comb begin
    case (opcode)
      `RV_OP_LUI:                result = imm_u;
      `RV_OP_AUIPC:              result = pc_i + imm_u;
      `RV_OP_JAL, `RV_OP_JALR:   result = pc_i + 4;
      default:                   result = alu_result_i;
    endcase
  end

  always_comb begin
    case (opcode)
      `RV_OP_JAL:  target = pc_i + imm_j;
      `RV_OP_JALR: target = {alu_result_i[`RV_XLEN-1:1], 1'b0};
      default:     target = pc_i + imm_b;
    endcase
  end

  assign writes_rd = (opcode == `RV_OP_REG) || (opcode == `RV_OP_IMM) ||
                     (opcode == `RV_OP_LUI) || (opcode == `RV_OP_AUIPC) ||
                     (opcode == `RV_OP_JAL) || (opcode == `RV_OP_JALR);
  assign we        = valid_i && writes_rd && (instr_i.uj.rd != '0);
  assign redirect  = valid_i && ((opcode == `RV_OP_JAL) || (opcode == `RV_OP_JALR) ||
                                 ((opcode == `RV_OP_BRANCH) && branch_taken_i));

  assign fwd_we_o   = we;
  assign fwd_rd_o   = instr_i.uj.rd;
  assign fwd_data_o = result;

  assign rf_we_o    = we;
  assign rf_waddr_o = instr_i.uj.rd;
  assign rf_wdata_o = result;

  always_ff @(posedge clock) begin
    if (reset) begin
      wb_valid_o       <= 1'b0;
      wb_we_o          <= 1'b0;
      redirect_valid_o <= 1'b0;
    end else begin
      wb_valid_o       <= valid_i;
      wb_we_o          <= we;
      redirect_valid_o <= redirect;
    end
  end

  always_ff @(posedge clock) begin
    wb_rd_o       <= instr_i.uj.rd;
    wb_data_o     <= result;
    redirect_pc_o <= target;
  end

endmodule

// File: source/rv_core.sv
`timescale 1ns/1ps
`include "rv_core_config.svh"

module rv_core import rv_core_pkg::*; (
  input  logic                      clock,
  input  logic                      reset,
  input  logic                      instr_valid_i,
  input  instr_t                    instr_i,
  input  logic [`RV_XLEN-1:0]       pc_i,
  output logic                      wb_valid_o,
  output logic                      wb_we_o,
  output logic [`RV_REG_ADDR_W-1:0] wb_rd_o,
  output logic [`RV_XLEN-1:0]       wb_data_o,
  output logic                      redirect_valid_o,
  output logic [`RV_XLEN-1:0]       redirect_pc_o
);

  logic [`RV_REG_ADDR_W-1:0] rs1_addr;
  logic [`RV_REG_ADDR_W-1:0] rs2_addr;
  logic [`RV_XLEN-1:0]       rs1_data;
  logic [`RV_XLEN-1:0]       rs2_data;

  logic                      dec_valid;
  instr_t                    dec_instr;
  logic [`RV_XLEN-1:0]       dec_pc;
  logic [`RV_XLEN-1:0]       op_a;
  logic [`RV_XLEN-1:0]       op_b;

  logic                      ex_valid;
  instr_t                    ex_instr;
  logic [`RV_XLEN-1:0]       ex_pc;
  logic [`RV_XLEN-1:0]       alu_result;
  logic                      branch_taken;

  logic                      fwd_we;
  logic [`RV_REG_ADDR_W-1:0] fwd_rd;
  logic [`RV_XLEN-1:0]       fwd_data;
  logic                      rf_we;
  logic [`RV_REG_ADDR_W-1:0] rf_waddr;
  logic [`RV_XLEN-1:0]       rf_wdata;

  rv_decoder u_decoder (
    .clock         (clock),
    .reset         (reset),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .pc_i          (pc_i),
    .rs1_addr_o    (rs1_addr),
    .rs2_addr_o    (rs2_addr),
    .rs1_data_i    (rs1_data),
    .rs2_data_i    (rs2_data),
    .fwd_we_i      (fwd_we),
    .fwd_rd_i      (fwd_rd),
    .fwd_data_i    (fwd_data),
    .valid_o       (dec_valid),
    .instr_o       (dec_instr),
    .pc_o          (dec_pc),
    .op_a_o        (op_a),
    .op_b_o        (op_b)
  );

  rv_regfile u_regfile (
    .clock      (clock),
    .reset      (reset),
    .rs1_addr_i (rs1_addr),
    .rs2_addr_i (rs2_addr),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data),
    .we_i       (rf_we),
    .waddr_i    (rf_waddr),
    .wdata_i    (rf_wdata)
  );

  rv_execute u_execute (
    .clock          (clock),
    .reset          (reset),
    .valid_i        (dec_valid),
    .instr_i        (dec_instr),
    .pc_i           (dec_pc),
    .op_a_i         (op_a),
    .op_b_i         (op_b),
    .valid_o        (ex_valid),
    .instr_o        (ex_instr),
    .pc_o           (ex_pc),
    .alu_result_o   (alu_result),
    .branch_taken_o (branch_taken)
  );

  rv_writeback u_writeback (
    .clock            (clock),
    .reset            (reset),
    .valid_i          (ex_valid),
    .instr_i          (ex_instr),
    .pc_i             (ex_pc),
    .alu_result_i     (alu_result),
    .branch_taken_i   (branch_taken),
    .fwd_we_o         (fwd_we),
    .fwd_rd_o         (fwd_rd),
    .fwd_data_o       (fwd_data),
    .rf_we_o          (rf_we),
    .rf_waddr_o       (rf_waddr),
    .rf_wdata_o       (rf_wdata),
    .wb_valid_o       (wb_valid_o),
    .wb_we_o          (wb_we_o),
    .wb_rd_o          (wb_rd_o),
    .wb_data_o        (wb_data_o),
    .redirect_valid_o (redirect_valid_o),
    .redirect_pc_o    (redirect_pc_o)
  );

endmodule

// File: test/rv_core_checker.sv
`timescale 1ns/1ps
`include "rv_core_config.svh"

module rv_core_checker (
  input  logic                      clock,
  input  logic                      reset,
  input  logic                      instr_valid_i,
  input  logic                      wb_valid_o,
  input  logic                      wb_we_o,
  input  logic [`RV_REG_ADDR_W-1:0] wb_rd_o,
  input  logic                      redirect_valid_o
);

  int unsigned fail_count = 0;

  // sampled at edge E, retirement registers at E+2 and is seen at E+3
  a_latency: assert property (@(posedge clock) disable iff (reset)
    instr_valid_i |-> ##3 wb_valid_o)
    else begin
      fail_count++;
      $error("strobed instruction did not retire two edges later");
    end

  a_redirect: assert property (@(posedge clock) disable iff (reset)
    redirect_valid_o |-> wb_valid_o)
    else begin
      fail_count++;
      $error("redirect without a retirement");
    end

  a_no_x0_write: assert property (@(posedge clock) disable iff (reset)
    (wb_valid_o && wb_we_o) |-> (wb_rd_o != '0))
    else begin
      fail_count++;
      $error("register write to x0");
    end

  a_quiet_after_reset: assert property (@(posedge clock)
    $fell(reset) |-> !wb_valid_o ##1 !wb_valid_o)
    else begin
      fail_count++;
      $error("retirement right after reset");
    end

endmodule

bind rv_core rv_core_checker u_checker (
  .clock            (clock),
  .reset            (reset),
  .instr_valid_i    (instr_valid_i),
  .wb_valid_o       (wb_valid_o),
  .wb_we_o          (wb_we_o),
  .wb_rd_o          (wb_rd_o),
  .redirect_valid_o (redirect_valid_o)
);

// File: test/rv_core_tb.sv
`timescale 1ns/1ps
`include "rv_core_config.svh"

module rv_core_tb import rv_core_pkg::*; ();

  localparam int NUM_INSTR    = 2000;
  localparam int VALID_PCT    = 75;
  localparam int CLK_PERIOD   = 20;
  localparam int RESET_CYCLES = 3;
  localparam int DRAIN_CYCLES = 5;
  // twice the expected cycle count at the strobe rate, plus reset and drain
  localparam int MAX_CYCLES   = NUM_INSTR * 200 / VALID_PCT + RESET_CYCLES + 50;
  localparam logic [31:0] SEED = 32'hc086_87df;

  typedef struct packed {
    logic                      we;
    logic [`RV_REG_ADDR_W-1:0] rd;
    logic [`RV_XLEN-1:0]       data;
    logic                      redirect;
    logic [`RV_XLEN-1:0]       target;
  } retire_t;

  logic                      clock;
  logic                      reset;
  logic                      instr_valid_i;
  instr_t                    instr_i;
  logic [`RV_XLEN-1:0]       pc_i;
  logic                      wb_valid_o;
  logic                      wb_we_o;
  logic [`RV_REG_ADDR_W-1:0] wb_rd_o;
  logic [`RV_XLEN-1:0]       wb_data_o;
  logic                      redirect_valid_o;
  logic [`RV_XLEN-1:0]       redirect_pc_o;

  logic [`RV_XLEN-1:0] model_regs [`RV_REG_COUNT];
  retire_t             expected_q [$];
  int                  issued;

  rv_core uut (
    .clock            (clock),
    .reset            (reset),
    .instr_valid_i    (instr_valid_i),
    .instr_i          (instr_i),
    .pc_i             (pc_i),
    .wb_valid_o       (wb_valid_o),
    .wb_we_o          (wb_we_o),
    .wb_rd_o          (wb_rd_o),
    .wb_data_o        (wb_data_o),
    .redirect_valid_o (redirect_valid_o),
    .redirect_pc_o    (redirect_pc_o)
  );

  initial begin
    clock = 1'b0;
    forever #(CLK_PERIOD / 2) clock = ~clock;
  end

  task automatic abort_run(input string reason);
    $display("ERROR: %s", reason);
    $display("STATUS: FAIL");
    $fatal(1, "run aborted");
  endtask

  task automatic check_equal(input string field, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("MISMATCH at %0t: %s is %h, expected %h", $time, field, actual, expected);
      abort_run("retired value differs from the model");
    end
  endtask

  function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
    logic [31:0] res;
    case (f3)
      3'd0: res = alt ? a - b : a + b;
      3'd1: res = a << b[4:0];
      3'd2: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3: res = (a < b) ? 32'd1 : 32'd0;
      3'd4: res = a ^ b;
      3'd5: begin
        if (alt) begin
          res = $signed(a) >>> b[4:0];
        end else begin
          res = a >> b[4:0];
        end
      end
      3'd6: res = a | b;
      default: res = a & b;
    endcase
    return res;
  endfunction

  function automatic logic branch_ref(input logic [2:0] f3, input logic [31:0] a,
                                      input logic [31:0] b);
    case (f3)
      3'd0: return a == b;
      3'd1: return a != b;
      3'd4: return $signed(a) < $signed(b);
      3'd5: return $signed(a) >= $signed(b);
      3'd6: return a < b;
      default: return a >= b;
    endcase
  endfunction

  function automatic logic [4:0] random_reg();
    return 5'($urandom_range(0, 7));
  endfunction

  // registers limited to x0..x7 so back-to-back dependencies are common
  function automatic logic [31:0] random_instr();
    logic [31:0] w;
    logic [2:0]  f3;
    w  = $urandom();
    f3 = 3'($urandom_range(0, 7));
    w[11:7]  = random_reg();
    w[14:12] = f3;
    case ($urandom_range(0, 11))
      0, 1, 2: begin
        w[31:25] = ((f3 == 3'd0 || f3 == 3'd5) && w[30]) ? 7'h20 : 7'h00;
        w[24:20] = random_reg();
        w[19:15] = random_reg();
        w[6:0]   = `RV_OP_REG;
      end
      3, 4, 5: begin
        if (f3 == 3'd1) begin
          w[31:25] = 7'h00;
        end else if (f3 == 3'd5) begin
          w[31:25] = w[30] ? 7'h20 : 7'h00;
        end
        w[19:15] = random_reg();
        w[6:0]   = `RV_OP_IMM;
      end
      6: w[6:0] = `RV_OP_LUI;
      7: w[6:0] = `RV_OP_AUIPC;
      8: w[6:0] = `RV_OP_JAL;
      9: begin
        w[14:12] = 3'd0;
        w[19:15] = random_reg();
        w[6:0]   = `RV_OP_JALR;
      end
      default: begin
        // funct3 2 and 3 are not branches
        if (f3 == 3'd2 || f3 == 3'd3) begin
          w[14:12] = f3 ^ 3'b110;
        end
        // the rd field carries immediate bits here
        w[11:7]  = 5'($urandom());
        w[24:20] = random_reg();
        w[19:15] = random_reg();
        w[6:0]   = `RV_OP_BRANCH;
      end
    endcase
    return w;
  endfunction

  task automatic issue_model(input logic [31:0] w, input logic [31:0] pc);
    retire_t     ret;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_i;
    logic [31:0] imm_b;
    logic [31:0] imm_j;
    logic [31:0] imm_u;
    a     = model_regs[w[19:15]];
    b     = model_regs[w[24:20]];
    imm_i = {{20{w[31]}}, w[31:20]};
    imm_b = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
    imm_j = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
    imm_u = {w[31:12], 12'b0};
    ret    = '0;
    ret.rd = w[11:7];
    ret.we = (w[11:7] != 5'd0);
    case (w[6:0])
      `RV_OP_REG:   ret.data = alu_ref(w[14:12], w[30], a, b);
      `RV_OP_IMM:   ret.data = alu_ref(w[14:12], w[30] && (w[14:12] == 3'd5), a, imm_i);
      `RV_OP_LUI:   ret.data = imm_u;
      `RV_OP_AUIPC: ret.data = pc + imm_u;
      `RV_OP_JAL: begin
        ret.data     = pc + 32'd4;
        ret.redirect = 1'b1;
        ret.target   = pc + imm_j;
      end
      `RV_OP_JALR: begin
        ret.data     = pc + 32'd4;
        ret.redirect = 1'b1;
        ret.target   = (a + imm_i) & ~32'd1;
      end
      default: begin
        ret.we       = 1'b0;
        ret.redirect = branch_ref(w[14:12], a, b);
        ret.target   = pc + imm_b;
      end
    endcase
    if (ret.we) begin
      model_regs[ret.rd] = ret.data;
    end
    expected_q.push_back(ret);
  endtask

  task automatic check_retire();
    retire_t ret;
    if (uut.u_checker.fail_count != 0) begin
      abort_run("a protocol assertion on the core ports failed");
    end else if (!wb_valid_o) begin
      check_equal("redirect_valid_o", 32'(redirect_valid_o), 32'd0);
    end else if (expected_q.size() == 0) begin
      abort_run("core retired an instruction that was never issued");
    end else begin
      ret = expected_q.pop_front();
      check_equal("wb_we_o", 32'(wb_we_o), 32'(ret.we));
      if (ret.we) begin
        check_equal("wb_rd_o", 32'(wb_rd_o), 32'(ret.rd));
        check_equal("wb_data_o", wb_data_o, ret.data);
      end
      check_equal("redirect_valid_o", 32'(redirect_valid_o), 32'(ret.redirect));
      if (ret.redirect) begin
        check_equal("redirect_pc_o", redirect_pc_o, ret.target);
      end
    end
  endtask

  initial begin
    #(MAX_CYCLES * CLK_PERIOD);
    abort_run("watchdog expired before all instructions retired");
  end

  initial begin
    logic [31:0] word;
    logic [31:0] pc;
    void'($urandom(SEED));
    reset         = 1'b1;
    instr_valid_i = 1'b0;
    instr_i       = '0;
    pc_i          = '0;
    issued        = 0;
    for (int n = 0; n < `RV_REG_COUNT; n++) begin
      model_regs[n] = '0;
    end
    repeat (RESET_CYCLES) @(negedge clock);
    reset = 1'b0;
    while (issued < NUM_INSTR) begin
      @(negedge clock);
      check_retire();
      if ($urandom_range(0, 99) < VALID_PCT) begin
        word = random_instr();
        pc   = $urandom() & ~32'd3;
        instr_valid_i = 1'b1;
        instr_i       = word;
        pc_i          = pc;
        issue_model(word, pc);
        issued++;
      end else begin
        // junk on idle cycles must not be captured
        instr_valid_i = 1'b0;
        instr_i       = $urandom();
        pc_i          = $urandom();
      end
    end
    @(negedge clock);
    check_retire();
    instr_valid_i = 1'b0;
    repeat (DRAIN_CYCLES) begin
      @(negedge clock);
      check_retire();
    end
    if (expected_q.size() == 0 && uut.u_checker.fail_count == 0) begin
      $display("STATUS: PASS");
      $finish;
    end else begin
      abort_run("instructions still outstanding after the pipeline drained");
    end
  end

endmodule

// File: filelist.f
+incdir+include
source/rv_core_pkg.sv
source/rv_regfile.sv
source/rv_decoder.sv
source/rv_execute.sv
source/rv_writeback.sv
source/rv_core.sv
test/rv_core_checker.sv
test/rv_core_tb.sv
